// File: logic/fb_read_pkg.sv
// Address and ID widths are fixed for every instance and one vector holds at most 16 pixels
package fb_read_pkg;

    ////////////////////////////////////////
    // Fixed widths
    ////////////////////////////////////////

    // Byte address width of the read port, also used for pixel indices
    localparam int ADDR_WIDTH = 32;

    // AXI ID width of the read address channel
    localparam int ID_WIDTH = 8;

    // Width of the lane field in an order record
    localparam int MAX_LANE_WIDTH = 4;

    ////////////////////////////////////////
    // Default module parameters
    ////////////////////////////////////////

    // One read data beat carries one vector of this many bits
    localparam int DEFAULT_DATA_WIDTH = 32;

    // Width of one pixel inside a vector
    localparam int DEFAULT_PIXEL_WIDTH = 16;

    // Number of order records the queue can hold
    localparam int DEFAULT_FIFO_DEPTH = 8;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [ID_WIDTH-1:0]       axi_id_t;
    typedef logic [MAX_LANE_WIDTH-1:0] lane_t;

    // One record per accepted pixel, in fetch order
    typedef struct packed {
        lane_t lane;
        logic  new_vector;
        logic  last;
    } fetch_order_t;

    // Read address fields produced by the request generator
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

endpackage

// File: logic/fetch_order_fifo.sv
// Pushes while full and pops while empty are ignored and the head is valid one cycle after a push
`timescale 1ns/10ps

module fetch_order_fifo #(
    parameter int DEPTH = fb_read_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      order_push,
    input  fb_read_pkg::fetch_order_t order_in,
    output logic                      order_full,
    input  logic                      order_pop,
    output logic                      order_valid,
    output fb_read_pkg::fetch_order_t order_out
);
    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    fb_read_pkg::fetch_order_t entries [DEPTH];
    logic [PTR_WIDTH-1:0]      wr_ptr;
    logic [PTR_WIDTH-1:0]      rd_ptr;
    logic [COUNT_WIDTH-1:0]    count;
    logic                      do_push;
    logic                      do_pop;

    assign order_full  = (count == COUNT_WIDTH'(DEPTH));
    assign order_valid = (count != '0);
    assign order_out   = entries[rd_ptr];

    assign do_push = order_push && !order_full;
    assign do_pop  = order_pop && order_valid;

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage for the records
    always_ff @(posedge aclk)
    begin
        if (do_push)
        begin
            entries[wr_ptr] <= order_in;
        end
    end

    // The extractor only takes records that exist
    no_pop_empty_a: assert property (@(posedge aclk) disable iff (!resetn)
        order_pop |-> order_valid);

endmodule

// File: logic/framebuffer_read_unit.sv
// Memory must answer reads in order and base_addr is sampled when each request launches
`timescale 1ns/10ps

module framebuffer_read_unit #(
    parameter int DATA_WIDTH  = fb_read_pkg::DEFAULT_DATA_WIDTH,
    parameter int PIXEL_WIDTH = fb_read_pkg::DEFAULT_PIXEL_WIDTH,
    parameter int FIFO_DEPTH  = fb_read_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                   aclk,
    input  logic                   resetn,
    input  fb_read_pkg::addr_t     base_addr,
    input  logic                   fetch_valid,
    input  logic                   fetch_last,
    input  fb_read_pkg::addr_t     fetch_index,
    output logic                   fetch_ready,
    output fb_read_pkg::axi_ar_t   mem_ar,
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    input  logic [DATA_WIDTH-1:0]  mem_rdata,
    input  logic                   mem_rvalid,
    output logic                   mem_rready,
    output logic [PIXEL_WIDTH-1:0] pix_data,
    output logic                   pix_last,
    output logic                   pix_valid,
    input  logic                   pix_ready
);
    // Order queue links
    logic                      order_push;
    fb_read_pkg::fetch_order_t order_in;
    logic                      order_full;
    logic                      order_valid;
    fb_read_pkg::fetch_order_t order_out;
    logic                      order_pop;

    // Turns the index stream into vector reads and order records
    read_request_generator #(
        .DATA_WIDTH  (DATA_WIDTH),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) read_request_generator_inst (
        .aclk        (aclk),
        .resetn      (resetn),
        .base_addr   (base_addr),
        .fetch_valid (fetch_valid),
        .fetch_last  (fetch_last),
        .fetch_index (fetch_index),
        .fetch_ready (fetch_ready),
        .mem_ar      (mem_ar),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .order_push  (order_push),
        .order_in    (order_in),
        .order_full  (order_full)
    );

    // Its depth bounds the pixels in flight
    fetch_order_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fetch_order_fifo_inst (
        .aclk        (aclk),
        .resetn      (resetn),
        .order_push  (order_push),
        .order_in    (order_in),
        .order_full  (order_full),
        .order_pop   (order_pop),
        .order_valid (order_valid),
        .order_out   (order_out)
    );

    pixel_extractor #(
        .DATA_WIDTH  (DATA_WIDTH),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) pixel_extractor_inst (
        .aclk        (aclk),
        .resetn      (resetn),
        .order_valid (order_valid),
        .order_out   (order_out),
        .order_pop   (order_pop),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .pix_data    (pix_data),
        .pix_last    (pix_last),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready)
    );

endmodule

// File: logic/pixel_extractor.sv
// Read data must come back in request order and lanes must lie inside one vector
`timescale 1ns/10ps

module pixel_extractor #(
    parameter int DATA_WIDTH  = fb_read_pkg::DEFAULT_DATA_WIDTH,
    parameter int PIXEL_WIDTH = fb_read_pkg::DEFAULT_PIXEL_WIDTH
) (
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      order_valid,
    input  fb_read_pkg::fetch_order_t order_out,
    output logic                      order_pop,
    input  logic [DATA_WIDTH-1:0]     mem_rdata,
    input  logic                      mem_rvalid,
    output logic                      mem_rready,
    output logic [PIXEL_WIDTH-1:0]    pix_data,
    output logic                      pix_last,
    output logic                      pix_valid,
    input  logic                      pix_ready
);
    logic [DATA_WIDTH-1:0]  vector_q;
    logic [DATA_WIDTH-1:0]  src_vector;
    logic [PIXEL_WIDTH-1:0] lane_pixel;
    logic                   out_free;

    ////////////////////////////////////////
    // Record handling
    ////////////////////////////////////////

    // The output register can take a pixel when it is empty or being drained
    assign out_free = !pix_valid || pix_ready;

    // A beat is only taken for a record that opens a new vector
    assign mem_rready = order_valid && out_free && order_out.new_vector;

    // Records that reuse the held vector need no beat
    assign order_pop = order_valid && out_free && (!order_out.new_vector || mem_rvalid);

    // A new vector is used straight from the bus in the cycle it arrives
    assign src_vector = order_out.new_vector ? mem_rdata : vector_q;
    assign lane_pixel = src_vector[order_out.lane * PIXEL_WIDTH +: PIXEL_WIDTH];

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            pix_valid <= 1'b0;
        end
        else if (order_pop)
        begin
            pix_valid <= 1'b1;
        end
        else if (pix_ready)
        begin
            pix_valid <= 1'b0;
        end
    end

    // Pixel and vector data are only loaded on a pop
    always_ff @(posedge aclk)
    begin
        if (order_pop)
        begin
            pix_data <= lane_pixel;
            pix_last <= order_out.last;
        end
        if (order_pop && order_out.new_vector)
        begin
            vector_q <= mem_rdata;
        end
    end

    // A stalled pixel holds its value until the sink takes it
    pix_stable_a: assert property (@(posedge aclk) disable iff (!resetn)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_last));

endmodule

// File: logic/read_request_generator.sv
// Needs DATA_WIDTH/PIXEL_WIDTH to be a power of two of at most 16 and base_addr stable during a run
`timescale 1ns/10ps

module read_request_generator #(
    parameter int DATA_WIDTH  = fb_read_pkg::DEFAULT_DATA_WIDTH,
    parameter int PIXEL_WIDTH = fb_read_pkg::DEFAULT_PIXEL_WIDTH
) (
    input  logic                      aclk,
    input  logic                      resetn,
    input  fb_read_pkg::addr_t        base_addr,
    input  logic                      fetch_valid,
    input  logic                      fetch_last,
    input  fb_read_pkg::addr_t        fetch_index,
    output logic                      fetch_ready,
    output fb_read_pkg::axi_ar_t      mem_ar,
    output logic                      mem_arvalid,
    input  logic                      mem_arready,
    output logic                      order_push,
    output fb_read_pkg::fetch_order_t order_in,
    input  logic                      order_full
);
    localparam int PIXELS_PER_VECTOR   = DATA_WIDTH / PIXEL_WIDTH;
    localparam int BYTES_PER_VECTOR    = DATA_WIDTH / 8;
    localparam logic [2:0] AR_SIZE     = 3'($clog2(BYTES_PER_VECTOR));
    localparam logic [1:0] BURST_INCR  = 2'b01;

    fb_read_pkg::addr_t   index_vector;
    fb_read_pkg::lane_t   index_lane;
    logic                 new_vector;
    logic                 fetch_fire;
    logic                 tag_valid;
    fb_read_pkg::addr_t   last_tag;
    logic                 req_pending;
    fb_read_pkg::addr_t   req_vector;
    logic                 skid_full;
    fb_read_pkg::addr_t   skid_vector;
    fb_read_pkg::axi_id_t ar_id;
    fb_read_pkg::addr_t   ar_addr;

    ////////////////////////////////////////
    // Fetch side
    ////////////////////////////////////////

    // Split the pixel index into its vector number and its lane
    assign index_vector = fb_read_pkg::addr_t'(fetch_index / PIXELS_PER_VECTOR);
    assign index_lane   = fb_read_pkg::lane_t'(fetch_index % PIXELS_PER_VECTOR);

    // A fresh beat is needed after reset, after tlast, or when the vector changes
    assign new_vector = !tag_valid || (index_vector != last_tag);

    // The stream stalls while a crossing waits in the skid slot or the queue is full
    assign fetch_ready = !skid_full && !order_full;
    assign fetch_fire  = fetch_valid && fetch_ready;

    // Every accepted pixel leaves one record for the extractor
    assign order_push          = fetch_fire;
    assign order_in.lane       = index_lane;
    assign order_in.new_vector = new_vector;
    assign order_in.last       = fetch_last;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            tag_valid   <= 1'b0;
            req_pending <= 1'b0;
            skid_full   <= 1'b0;
        end
        else
        begin
            if (fetch_fire)
            begin
                // After tlast the tag is invalid so the next run always reads again
                tag_valid <= !fetch_last;
                if (new_vector)
                begin
                    // A second crossing parks in the skid slot while one request waits
                    if (req_pending)
                    begin
                        skid_full <= 1'b1;
                    end
                    else
                    begin
                        req_pending <= 1'b1;
                    end
                end
            end
            // The skid entry moves up once the pending slot is free
            if (skid_full && !req_pending)
            begin
                req_pending <= 1'b1;
                skid_full   <= 1'b0;
            end
            // The pending request leaves when the address channel is idle
            if (req_pending && !mem_arvalid)
            begin
                req_pending <= 1'b0;
            end
        end
    end

    // Vector numbers have no reset since tag_valid and the slot flags qualify them
    always_ff @(posedge aclk)
    begin
        if (fetch_fire)
        begin
            last_tag <= index_vector;
        end
        if (fetch_fire && new_vector && req_pending)
        begin
            skid_vector <= index_vector;
        end
        else if (fetch_fire && new_vector)
        begin
            req_vector <= index_vector;
        end
        else if (skid_full && !req_pending)
        begin
            req_vector <= skid_vector;
        end
    end

    ////////////////////////////////////////
    // Read address channel
    ////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            mem_arvalid <= 1'b0;
            ar_id       <= '0;
        end
        else if (!mem_arvalid)
        begin
            if (req_pending)
            begin
                mem_arvalid <= 1'b1;
                ar_id       <= ar_id + 1'b1;
            end
        end
        else if (mem_arready)
        begin
            mem_arvalid <= 1'b0;
        end
    end

    // The address is only loaded while arvalid is low so it holds through a stall
    always_ff @(posedge aclk)
    begin
        if (!mem_arvalid && req_pending)
        begin
            ar_addr <= base_addr + fb_read_pkg::addr_t'(req_vector * BYTES_PER_VECTOR);
        end
    end

    // Single beat reads of one full vector
    always_comb
    begin
        mem_ar.id    = ar_id;
        mem_ar.addr  = ar_addr;
        mem_ar.len   = 8'd0;
        mem_ar.size  = AR_SIZE;
        mem_ar.burst = BURST_INCR;
    end

    // The slave sees a stable request until it takes it
    ar_stable_a: assert property (@(posedge aclk) disable iff (!resetn)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar));

    // The queue never receives a record it has no room for
    no_push_full_a: assert property (@(posedge aclk) disable iff (!resetn)
        order_full |-> !order_push);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f verilog.f --top-module framebuffer_read_unit_tb -o sim_framebuffer_read_unit

./obj_dir/sim_framebuffer_read_unit 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: verification/axi_read_memory_model.sv
// Answers reads in request order, base_addr must not change while reads are outstanding
`timescale 1ns/10ps

module axi_read_memory_model #(
    parameter int DATA_WIDTH  = fb_read_pkg::DEFAULT_DATA_WIDTH,
    parameter int PIXEL_WIDTH = fb_read_pkg::DEFAULT_PIXEL_WIDTH,
    parameter int MAX_DELAY   = 5
) (
    input  logic                  aclk,
    input  logic                  resetn,
    input  fb_read_pkg::addr_t    base_addr,
    input  fb_read_pkg::axi_ar_t  mem_ar,
    input  logic                  mem_arvalid,
    output logic                  mem_arready,
    output logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  mem_rvalid,
    input  logic                  mem_rready
);
    localparam int PIXELS_PER_VECTOR = DATA_WIDTH / PIXEL_WIDTH;
    localparam int BYTES_PER_VECTOR  = DATA_WIDTH / 8;

    // Every accepted address stays here, returned_count walks through it in order
    fb_read_pkg::addr_t read_queue [$];
    int                 taken_count    = 0;
    int                 returned_count = 0;
    int                 delay_left     = -1;

    // Each pixel slice holds its own index folded with a fixed pattern
    function automatic logic [DATA_WIDTH-1:0] vector_data(input fb_read_pkg::addr_t addr);
        fb_read_pkg::addr_t    first_index;
        logic [DATA_WIDTH-1:0] data;
        first_index = ((addr - base_addr) / BYTES_PER_VECTOR) * PIXELS_PER_VECTOR;
        for (int lane = 0; lane < PIXELS_PER_VECTOR; lane++)
        begin
            data[lane*PIXEL_WIDTH +: PIXEL_WIDTH] =
                PIXEL_WIDTH'(first_index + fb_read_pkg::addr_t'(lane)) ^ PIXEL_WIDTH'(16'h5a5a);
        end
        return data;
    endfunction

    ////////////////////////////////////////
    // Handshakes seen at the rising edge
    ////////////////////////////////////////

    always @(posedge aclk)
    begin
        if (resetn && mem_arvalid && mem_arready)
        begin
            read_queue.push_back(mem_ar.addr);
        end
        if (resetn && mem_rvalid && mem_rready)
        begin
            taken_count++;
        end
    end

    ////////////////////////////////////////
    // Outputs change on the falling edge
    ////////////////////////////////////////

    initial
    begin
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        forever
        begin
            @(negedge aclk);
            if (!resetn)
            begin
                mem_arready = 1'b0;
                mem_rvalid  = 1'b0;
            end
            else
            begin
                // Roughly one cycle in four stalls the address channel
                mem_arready = (($urandom % 4) != 0);
                // The beat on the bus was taken once the two counts meet
                if (taken_count == returned_count)
                begin
                    mem_rvalid = 1'b0;
                end
                if (!mem_rvalid && (returned_count < read_queue.size()))
                begin
                    if (delay_left < 0)
                    begin
                        delay_left = int'($urandom % (MAX_DELAY + 1));
                    end
                    if (delay_left == 0)
                    begin
                        mem_rdata  = vector_data(read_queue[returned_count]);
                        mem_rvalid = 1'b1;
                        returned_count++;
                        delay_left = -1;
                    end
                    else
                    begin
                        delay_left--;
                    end
                end
            end
        end
    end

endmodule

// File: verification/framebuffer_read_unit_tb.sv
// Runs the unit with its default parameters and changes base_addr only while nothing is in flight
`timescale 1ns/10ps

module framebuffer_read_unit_tb;

    localparam int          DATA_WIDTH        = fb_read_pkg::DEFAULT_DATA_WIDTH;
    localparam int          PIXEL_WIDTH       = fb_read_pkg::DEFAULT_PIXEL_WIDTH;
    localparam int          PIXELS_PER_VECTOR = DATA_WIDTH / PIXEL_WIDTH;
    localparam int          BYTES_PER_VECTOR  = DATA_WIDTH / 8;
    localparam int          TIMEOUT_CYCLES    = 20000;
    localparam int          RANDOM_PIXELS     = 200;
    localparam int          RANDOM_INDEX_SPAN = 24;
    localparam logic [31:0] SEED              = 32'h7493_b337;

    // One expected output pixel together with its tlast
    typedef struct packed {
        logic                   last;
        logic [PIXEL_WIDTH-1:0] data;
    } pixel_t;

    logic                   aclk;
    logic                   resetn;
    fb_read_pkg::addr_t     base_addr;
    logic                   fetch_valid;
    logic                   fetch_last;
    fb_read_pkg::addr_t     fetch_index;
    logic                   fetch_ready;
    fb_read_pkg::axi_ar_t   mem_ar;
    logic                   mem_arvalid;
    logic                   mem_arready;
    logic [DATA_WIDTH-1:0]  mem_rdata;
    logic                   mem_rvalid;
    logic                   mem_rready;
    logic [PIXEL_WIDTH-1:0] pix_data;
    logic                   pix_last;
    logic                   pix_valid;
    logic                   pix_ready;

    // Scoreboards filled in fetch order and emptied by the monitors
    pixel_t             expected_pixels [$];
    fb_read_pkg::addr_t expected_vectors [$];
    fb_read_pkg::addr_t prev_vector;
    logic               prev_last;
    logic               first_pixel;
    int                 crossing_count = 0;
    int                 read_count     = 0;
    int                 cycle_count    = 0;
    int                 pix_stall_pct  = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (10)
    ) tb_clock_gen_inst (
        .aclk   (aclk),
        .resetn (resetn)
    );

    framebuffer_read_unit framebuffer_read_unit_inst (
        .aclk        (aclk),
        .resetn      (resetn),
        .base_addr   (base_addr),
        .fetch_valid (fetch_valid),
        .fetch_last  (fetch_last),
        .fetch_index (fetch_index),
        .fetch_ready (fetch_ready),
        .mem_ar      (mem_ar),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .pix_data    (pix_data),
        .pix_last    (pix_last),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready)
    );

    axi_read_memory_model #(
        .DATA_WIDTH  (DATA_WIDTH),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) axi_read_memory_model_inst (
        .aclk        (aclk),
        .resetn      (resetn),
        .base_addr   (base_addr),
        .mem_ar      (mem_ar),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready)
    );

    ////////////////////////////////////////
    // Reporting and reference values
    ////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got === expected)
        else
        begin
            abort_run($sformatf("FAIL time %0t %s got 0x%0h expected 0x%0h",
                                $time, name, got, expected));
        end
    endtask

    // Memory holds the low index bits of each pixel folded with 16'h5a5a
    function automatic logic [PIXEL_WIDTH-1:0] pixel_value(input fb_read_pkg::addr_t index);
        return PIXEL_WIDTH'(index) ^ PIXEL_WIDTH'(16'h5a5a);
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic send_pixel(input fb_read_pkg::addr_t index, input logic last);
        fb_read_pkg::addr_t vector;
        pixel_t             pixel;
        vector = index / PIXELS_PER_VECTOR;
        // A read is due after reset, after tlast or on a new vector
        if (first_pixel || prev_last || (vector != prev_vector))
        begin
            expected_vectors.push_back(vector);
            crossing_count++;
        end
        first_pixel = 1'b0;
        prev_last   = last;
        prev_vector = vector;
        pixel.last  = last;
        pixel.data  = pixel_value(index);
        expected_pixels.push_back(pixel);
        fetch_valid = 1'b1;
        fetch_index = index;
        fetch_last  = last;
        // fetch_ready only moves at a rising edge so its value now decides the next one
        while (!fetch_ready)
        begin
            @(negedge aclk);
        end
        @(negedge aclk);
    endtask

    // Waits for every expected pixel and read and then a few quiet cycles
    task automatic drain_outputs;
        fetch_valid = 1'b0;
        while ((expected_pixels.size() != 0) || (expected_vectors.size() != 0))
        begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_state;
        check_value("fetch_ready", 64'(fetch_ready), 64'(1));
        check_value("mem_arvalid", 64'(mem_arvalid), 64'(0));
        check_value("mem_rready", 64'(mem_rready), 64'(0));
        check_value("pix_valid", 64'(pix_valid), 64'(0));
    endtask

    // Two pixels per vector so 32 indices need 16 reads
    task automatic test_sequential_run;
        int start_reads;
        base_addr   = 32'h1000_0000;
        start_reads = read_count;
        for (int i = 0; i < 32; i++)
        begin
            send_pixel(fb_read_pkg::addr_t'(i), (i == 31));
        end
        drain_outputs();
        check_value("read count", 64'(read_count - start_reads), 64'(16));
    endtask

    task automatic test_vector_reuse;
        int start_reads;
        base_addr   = 32'h2000_0100;
        start_reads = read_count;
        // Same vector twice with tlast in between reads it twice
        send_pixel(32'd4, 1'b1);
        send_pixel(32'd5, 1'b1);
        drain_outputs();
        check_value("read count", 64'(read_count - start_reads), 64'(2));
        start_reads = read_count;
        // Repeats inside one vector share a single read
        send_pixel(32'd8, 1'b0);
        send_pixel(32'd9, 1'b0);
        send_pixel(32'd8, 1'b0);
        send_pixel(32'd9, 1'b1);
        drain_outputs();
        check_value("read count", 64'(read_count - start_reads), 64'(1));
    endtask

    task automatic test_random_stream;
        int                 start_reads;
        int                 start_crossings;
        fb_read_pkg::addr_t index;
        logic               last;
        base_addr       = 32'h3000_0000;
        pix_stall_pct   = 40;
        start_reads     = read_count;
        start_crossings = crossing_count;
        index           = '0;
        for (int n = 0; n < RANDOM_PIXELS; n++)
        begin
            // Runs of neighbours mixed with jumps
            if (($urandom % 3) == 0)
            begin
                index = index + 1'b1;
            end
            else
            begin
                index = fb_read_pkg::addr_t'($urandom % RANDOM_INDEX_SPAN);
            end
            last = (($urandom % 8) == 0);
            // Idle gaps in the fetch stream
            if (($urandom % 4) == 0)
            begin
                fetch_valid = 1'b0;
                @(negedge aclk);
            end
            send_pixel(index, last);
        end
        drain_outputs();
        pix_stall_pct = 0;
        check_value("read count", 64'(read_count - start_reads),
                    64'(crossing_count - start_crossings));
    endtask

    ////////////////////////////////////////
    // Monitors and watchdog
    ////////////////////////////////////////

    // Pixel sink with random stalls
    initial
    begin
        pix_ready = 1'b1;
        forever
        begin
            @(negedge aclk);
            pix_ready = (int'($urandom % 100) >= pix_stall_pct);
        end
    end

    always @(posedge aclk)
    begin : pixel_monitor
        pixel_t expected;
        if (resetn && pix_valid && pix_ready)
        begin
            assert (expected_pixels.size() != 0)
            else
            begin
                abort_run("A pixel came out with no fetch waiting for it");
            end
            expected = expected_pixels.pop_front();
            check_value("pix_data", 64'(pix_data), 64'(expected.data));
            check_value("pix_last", 64'(pix_last), 64'(expected.last));
        end
    end

    always @(posedge aclk)
    begin : address_monitor
        fb_read_pkg::addr_t vector;
        if (resetn && mem_arvalid && mem_arready)
        begin
            assert (expected_vectors.size() != 0)
            else
            begin
                abort_run("A read was issued that no fetched pixel needed");
            end
            vector = expected_vectors.pop_front();
            read_count++;
            check_value("mem_ar.addr", 64'(mem_ar.addr),
                        64'(base_addr + fb_read_pkg::addr_t'(vector * BYTES_PER_VECTOR)));
            // IDs count from 1 and wrap at the ID width
            check_value("mem_ar.id", 64'(mem_ar.id), 64'(fb_read_pkg::axi_id_t'(read_count)));
            check_value("mem_ar.len", 64'(mem_ar.len), 64'(0));
            check_value("mem_ar.size", 64'(mem_ar.size), 64'($clog2(BYTES_PER_VECTOR)));
            check_value("mem_ar.burst", 64'(mem_ar.burst), 64'(2'b01));
        end
    end

    always @(posedge aclk)
    begin : watchdog
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES)
        else
        begin
            abort_run("Timeout, the tests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        void'($urandom(SEED));
        base_addr   = 32'h1000_0000;
        fetch_valid = 1'b0;
        fetch_last  = 1'b0;
        fetch_index = '0;
        prev_vector = '0;
        prev_last   = 1'b0;
        first_pixel = 1'b1;
        wait (resetn === 1'b1);
        @(negedge aclk);
        test_reset_state();
        test_sequential_run();
        test_vector_reuse();
        test_random_stream();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
// Free running clock from time zero with resetn released on a falling edge after the reset cycles
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic aclk,
    output logic resetn
);
    // Clock starts low so the first rising edge comes half a period in
    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) aclk = ~aclk;
        end
    end

    // Reset is held for whole cycles and lifted where the stimulus changes
    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        resetn = 1'b1;
    end

endmodule

// File: verilog.f
logic/fb_read_pkg.sv
logic/read_request_generator.sv
logic/fetch_order_fifo.sv
logic/pixel_extractor.sv
logic/framebuffer_read_unit.sv
verification/tb_clock_gen.sv
verification/axi_read_memory_model.sv
verification/framebuffer_read_unit_tb.sv
